// File: build.f
+incdir+verilog
+incdir+sim
verilog/fp_add_pkg.sv
verilog/fp_sideband_if.sv
verilog/fp_classify.sv
verilog/fp_align.sv
verilog/fp_mantissa_add.sv
verilog/fp_normalize_round.sv
verilog/fp_add_top.sv
sim/fp_add_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module fp_add_tb -o fp_add_sim > compile.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat compile.log
    echo "compilation failed with status $status"
    exit 1
fi

./obj_dir/fp_add_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

// File: sim/fp_add_tests.svh
// directed tests of the adder, included into the testbench module body
`ifndef FP_ADD_TESTS_SVH
`define FP_ADD_TESTS_SVH

task automatic check_latency_and_reset();
    int errors_before;
    int cycles;
    bit found;
    errors_before = error_count;
    compare_hex("valid_data_out", valid_data_out, 0);
    compare_hex("out", out, 0);
    compare_hex("overflow", overflow, 0);
    compare_hex("underflow", underflow, 0);
    compare_hex("inexact", inexact, 0);
    compare_hex("invalid_operation", invalid_operation, 0);
    apply_op(32'h3F80_0000, 32'h4000_0000, rm_rne);
    wait_for_result(cycles, found);
    if (found) begin
        compare_hex("latency", cycles, 4);
    end
    report_test("latency and reset", errors_before);
endtask

task automatic exact_sums();
    int errors_before;
    errors_before = error_count;
    run_single(32'h3F80_0000, 32'h4000_0000, rm_rne, 32'h4040_0000, 4'b0000);
    run_single(32'h4040_0000, 32'hBF80_0000, rm_rne, 32'h4000_0000, 4'b0000);
    run_single(32'h3FC0_0000, 32'h3FC0_0000, rm_rne, 32'h4040_0000, 4'b0000);
    report_test("exact arithmetic", errors_before);
endtask

task automatic special_operands();
    int errors_before;
    errors_before = error_count;
    // quiet NaN unchanged, signalling NaN made quiet
    run_single(32'h7FC0_0001, 32'h3F80_0000, rm_rne, 32'h7FC0_0001, 4'b0000);
    run_single(32'h3F80_0000, 32'h7F80_0001, rm_rne, 32'h7FC0_0001, 4'b0001);
    run_single(32'h7F80_0000, 32'hFF80_0000, rm_rne, 32'h7FC0_0000, 4'b0001);
    run_single(32'h4040_0000, 32'hFF80_0000, rm_rne, 32'hFF80_0000, 4'b0000);
    // smallest denormal is flushed
    run_single(32'h0000_0001, 32'h3F80_0000, rm_rne, 32'h3F80_0000, 4'b0100);
    report_test("special results", errors_before);
endtask

task automatic rounding_modes();
    int errors_before;
    logic [2:0]  modes [5];
    logic [31:0] results [5];
    errors_before = error_count;
    modes   = '{rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm};
    results = '{32'h3F80_0001, 32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0001, 32'h3F80_0001};
    // 2^-24 + 2^-46 lands just above the halfway point of 1.0
    for (int i = 0; i < 5; i++) begin
        run_single(32'h3F80_0000, 32'h3380_0002, modes[i], results[i], 4'b0010);
    end
    report_test("rounding modes", errors_before);
endtask

task automatic cancellation_and_overflow();
    int errors_before;
    errors_before = error_count;
    run_single(32'h3F80_0000, 32'hBF80_0000, rm_rne, 32'h0000_0000, 4'b0000);
    run_single(32'h3F80_0000, 32'hBF80_0000, rm_rdn, 32'h8000_0000, 4'b0000);
    run_single(32'h7F7F_FFFF, 32'h7F7F_FFFF, rm_rne, 32'h7F80_0000, 4'b1000);
    run_single(32'h7F7F_FFFF, 32'h7F7F_FFFF, rm_rtz, 32'h7F7F_FFFF, 4'b1000);
    report_test("cancellation and overflow", errors_before);
endtask

task automatic back_to_back_stream();
    logic [31:0] op_a [20];
    logic [31:0] op_b [20];
    logic [31:0] expected [20];
    logic        exp_inexact [20];
    logic [24:0] mag;
    logic [31:0] r;
    int          errors_before;
    int          received;
    int          waited;
    errors_before = error_count;
    for (int i = 0; i < 20; i++) begin
        r       = $random(seed);
        op_a[i] = {1'b0, 8'd128, r[22:0]};
        r       = $random(seed);
        op_b[i] = {1'b0, 8'd128, r[22:0]};
        // two hidden bits always carry, so the exponent becomes 129
        mag            = {2'b01, op_a[i][22:0]} + {2'b01, op_b[i][22:0]};
        expected[i]    = {1'b0, 8'd129, mag[23:1]};
        exp_inexact[i] = mag[0];
    end
    fork
        begin
            @(posedge clk);
            #1;
            for (int i = 0; i < 20; i++) begin
                in1           = op_a[i];
                in2           = op_b[i];
                rounding_mode = rm_rtz;
                valid_data_in = 1'b1;
                @(posedge clk);
                #1;
            end
            valid_data_in = 1'b0;
        end
        begin
            received = 0;
            waited   = 0;
            while (received < 20 && waited < timeout_cycles) begin
                @(posedge clk);
                #1;
                if (valid_data_out) begin
                    compare_hex("out", out, expected[received]);
                    compare_hex("inexact", inexact, exp_inexact[received]);
                    received++;
                    waited = 0;
                end else begin
                    waited++;
                end
            end
            assert (received == 20) else begin
                $display("timeout: only %0d of 20 stream results arrived", received);
                error_count++;
            end
        end
    join
    report_test("back-to-back stream", errors_before);
endtask

`endif

// File: sim/fp_add_tb.sv
// testbench for the pipelined adder, drives fp_add_top through the directed tests of fp_add_tests.svh
`timescale 1ns/1ps
`default_nettype none

module fp_add_tb;

    localparam int timeout_cycles = 20;

    // rounding mode codes as seen on the top-level port
    localparam logic [2:0] rm_rne = 3'd0;
    localparam logic [2:0] rm_rtz = 3'd1;
    localparam logic [2:0] rm_rdn = 3'd2;
    localparam logic [2:0] rm_rup = 3'd3;
    localparam logic [2:0] rm_rmm = 3'd4;

    logic        clk;
    logic        rst;
    logic        valid_data_in;
    logic [31:0] in1;
    logic [31:0] in2;
    logic [2:0]  rounding_mode;
    logic [31:0] out;
    logic        overflow;
    logic        underflow;
    logic        inexact;
    logic        invalid_operation;
    logic        valid_data_out;

    integer error_count;
    integer tests_passed;
    integer tests_failed;
    integer seed;

    fp_add_top UUT (
        .clk               (clk),
        .rst               (rst),
        .valid_data_in     (valid_data_in),
        .in1               (in1),
        .in2               (in2),
        .rounding_mode     (rounding_mode),
        .out               (out),
        .overflow          (overflow),
        .underflow         (underflow),
        .inexact           (inexact),
        .invalid_operation (invalid_operation),
        .valid_data_out    (valid_data_out)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH %s: got %0h, expected %0h", name, got, expected);
            error_count++;
        end
    endtask

    // one valid cycle, returns 1 ns after the edge that sampled it
    task automatic apply_op(input logic [31:0] a, input logic [31:0] b, input logic [2:0] rm);
        @(posedge clk);
        #1;
        in1           = a;
        in2           = b;
        rounding_mode = rm;
        valid_data_in = 1'b1;
        @(posedge clk);
        #1;
        valid_data_in = 1'b0;
    endtask

    task automatic wait_for_result(output int cycles, output bit found);
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
            found = valid_data_out;
        end
        assert (found) else begin
            $display("timeout: valid_data_out did not rise within %0d cycles", timeout_cycles);
            error_count++;
        end
    endtask

    // flags given as {overflow, underflow, inexact, invalid_operation}
    task automatic run_single(input logic [31:0] a, input logic [31:0] b, input logic [2:0] rm,
                              input logic [31:0] exp_out, input logic [3:0] exp_flags);
        int cycles;
        bit found;
        apply_op(a, b, rm);
        wait_for_result(cycles, found);
        if (found) begin
            compare_hex("out", out, exp_out);
            compare_hex("overflow", overflow, exp_flags[3]);
            compare_hex("underflow", underflow, exp_flags[2]);
            compare_hex("inexact", inexact, exp_flags[1]);
            compare_hex("invalid_operation", invalid_operation, exp_flags[0]);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    `include "fp_add_tests.svh"

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        valid_data_in = 1'b0;
        in1           = '0;
        in2           = '0;
        rounding_mode = rm_rne;
        error_count   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        seed          = 32'hc96;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        check_latency_and_reset();
        exact_sums();
        special_operands();
        rounding_modes();
        cancellation_and_overflow();
        back_to_back_stream();

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fp_add_macros.svh
// width and constant definitions for the single-precision adder, included by the RTL files
`ifndef FP_ADD_MACROS_SVH
`define FP_ADD_MACROS_SVH

// field widths of an IEEE-754 single
`define FP_EXP_W 8
`define FP_MAN_W 23

// hidden bit, fraction, then guard, round and sticky
`define FP_EXT_W 27

// smaller operand is never shifted further than this
`define FP_MAX_SHIFT 24

// fraction bit that separates quiet from signalling NaN
`define FP_QNAN_BIT 22

// canonical quiet NaN for invalid operations
`define FP_DEFAULT_NAN 32'h7FC0_0000

// largest biased exponent of a finite number
`define FP_EXP_MAX_FINITE 254

`endif

// File: verilog/fp_add_pkg.sv
// shared types of the pipelined adder: float layout, rounding modes and stage payloads
`default_nettype none

`include "fp_add_macros.svh"

package fp_add_pkg;

    // single-precision layout, sign in the msb
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exponent;
        logic [`FP_MAN_W-1:0] mantissa;
    } fp32_t;

    // codes above RMM round like RTZ
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } round_mode_e;

    // stage 2 to stage 3 payload
    typedef struct packed {
        fp32_t                larger;
        logic [`FP_EXT_W-1:0] small_man;
        logic                 sticky;
        logic                 sub;
    } align_t;

    // stage 3 to stage 4 payload
    typedef struct packed {
        logic [`FP_EXT_W:0]   add_res;
        logic [`FP_EXT_W-1:0] sub_res;
        logic                 sign;
        logic [`FP_EXP_W-1:0] exponent;
        logic                 sticky;
        logic                 sub;
        logic                 exact_zero;
    } sum_t;

endpackage

`default_nettype wire

// File: verilog/fp_add_top.sv
// top level of the four-stage single-precision adder, plain ports to the surrounding logic
`timescale 1ns/1ps
`default_nettype none

module fp_add_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_data_in,
    input  logic [31:0] in1,
    input  logic [31:0] in2,
    input  logic [2:0]  rounding_mode,
    output logic [31:0] out,
    output logic        overflow,
    output logic        underflow,
    output logic        inexact,
    output logic        invalid_operation,
    output logic        valid_data_out
);

    fp_add_pkg::fp32_t  op1;
    fp_add_pkg::fp32_t  op2;
    fp_add_pkg::align_t aligned;
    fp_add_pkg::sum_t   sum;

    // side-band registered by stages 1, 2 and 3
    fp_sideband_if s2_sb ();
    fp_sideband_if s3_sb ();
    fp_sideband_if s4_sb ();

    fp_classify u_classify (
        .clk           (clk),
        .rst           (rst),
        .in1           (fp_add_pkg::fp32_t'(in1)),
        .in2           (fp_add_pkg::fp32_t'(in2)),
        .valid_data_in (valid_data_in),
        .rounding_mode (fp_add_pkg::round_mode_e'(rounding_mode)),
        .sb            (s2_sb.src),
        .op1           (op1),
        .op2           (op2)
    );

    fp_align u_align (
        .clk     (clk),
        .rst     (rst),
        .sb_in   (s2_sb.dst),
        .op1     (op1),
        .op2     (op2),
        .sb_out  (s3_sb.src),
        .aligned (aligned)
    );

    fp_mantissa_add u_mantissa_add (
        .clk     (clk),
        .rst     (rst),
        .sb_in   (s3_sb.dst),
        .aligned (aligned),
        .sb_out  (s4_sb.src),
        .sum     (sum)
    );

    fp_normalize_round u_normalize_round (
        .clk               (clk),
        .rst               (rst),
        .sb                (s4_sb.dst),
        .sum               (sum),
        .out               (out),
        .overflow          (overflow),
        .underflow         (underflow),
        .inexact           (inexact),
        .invalid_operation (invalid_operation),
        .valid_data_out    (valid_data_out)
    );

endmodule

`default_nettype wire

// File: verilog/fp_align.sv
// stage 2 of the adder: orders the operands by magnitude and aligns the smaller mantissa
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_align (
    input  logic                clk,
    input  logic                rst,
    fp_sideband_if.dst          sb_in,
    input  fp_add_pkg::fp32_t   op1,
    input  fp_add_pkg::fp32_t   op2,
    fp_sideband_if.src          sb_out,
    output fp_add_pkg::align_t  aligned
);

    logic                                  op1_larger;
    fp_add_pkg::fp32_t                     larger;
    fp_add_pkg::fp32_t                     smaller;
    logic [`FP_EXP_W-1:0]                  exp_diff;
    logic [4:0]                            shamt;
    logic [`FP_EXT_W+`FP_MAX_SHIFT-1:0]    shifted;

    // equal magnitudes keep op1 as the larger one
    assign op1_larger = (op1.exponent > op2.exponent) ||
                        ((op1.exponent == op2.exponent) && (op1.mantissa >= op2.mantissa));
    assign larger     = op1_larger ? op1 : op2;
    assign smaller    = op1_larger ? op2 : op1;
    assign exp_diff   = larger.exponent - smaller.exponent;
    assign shamt      = (exp_diff > `FP_MAX_SHIFT) ? 5'(`FP_MAX_SHIFT) : exp_diff[4:0];

    // low half collects whatever falls off the extended mantissa
    assign shifted = {1'b1, smaller.mantissa, 3'b000, {`FP_MAX_SHIFT{1'b0}}} >> shamt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aligned               <= '0;
            sb_out.valid          <= 1'b0;
            sb_out.round_mode     <= fp_add_pkg::RNE;
            sb_out.special_case   <= 1'b0;
            sb_out.special_result <= '0;
            sb_out.invalid        <= 1'b0;
            sb_out.flushed        <= 1'b0;
        end else begin
            aligned.larger        <= larger;
            aligned.small_man     <= shifted[`FP_EXT_W+`FP_MAX_SHIFT-1 -: `FP_EXT_W];
            aligned.sticky        <= |shifted[`FP_MAX_SHIFT-1:0];
            aligned.sub           <= op1.sign ^ op2.sign;
            sb_out.valid          <= sb_in.valid;
            sb_out.round_mode     <= sb_in.round_mode;
            sb_out.special_case   <= sb_in.special_case;
            sb_out.special_result <= sb_in.special_result;
            sb_out.invalid        <= sb_in.invalid;
            sb_out.flushed        <= sb_in.flushed;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp_classify.sv
// stage 1 of the adder: registers the operands, classifies them and registers the special result
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_classify (
    input  logic                    clk,
    input  logic                    rst,
    input  fp_add_pkg::fp32_t       in1,
    input  fp_add_pkg::fp32_t       in2,
    input  logic                    valid_data_in,
    input  fp_add_pkg::round_mode_e rounding_mode,
    fp_sideband_if.src              sb,
    output fp_add_pkg::fp32_t       op1,
    output fp_add_pkg::fp32_t       op2
);

    fp_add_pkg::fp32_t       a;
    fp_add_pkg::fp32_t       b;
    logic                    valid_q;
    fp_add_pkg::round_mode_e rm_q;
    logic                    a_zero, a_inf, a_qnan, a_snan, a_den;
    logic                    b_zero, b_inf, b_qnan, b_snan, b_den;
    logic                    special_c;
    fp_add_pkg::fp32_t       result_c;

    // input register, sampled together with valid_data_in
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a       <= '0;
            b       <= '0;
            valid_q <= 1'b0;
            rm_q    <= fp_add_pkg::RNE;
        end else begin
            a       <= in1;
            b       <= in2;
            valid_q <= valid_data_in;
            rm_q    <= rounding_mode;
        end
    end

    assign a_zero = (a.exponent == '0) && (a.mantissa == '0);
    assign a_den  = (a.exponent == '0) && (a.mantissa != '0);
    assign a_inf  = (a.exponent == '1) && (a.mantissa == '0);
    assign a_qnan = (a.exponent == '1) && a.mantissa[`FP_QNAN_BIT];
    assign a_snan = (a.exponent == '1) && (a.mantissa != '0) && !a.mantissa[`FP_QNAN_BIT];
    assign b_zero = (b.exponent == '0) && (b.mantissa == '0);
    assign b_den  = (b.exponent == '0) && (b.mantissa != '0);
    assign b_inf  = (b.exponent == '1) && (b.mantissa == '0);
    assign b_qnan = (b.exponent == '1) && b.mantissa[`FP_QNAN_BIT];
    assign b_snan = (b.exponent == '1) && (b.mantissa != '0) && !b.mantissa[`FP_QNAN_BIT];

    // special result priority, first match wins
    always_comb begin
        special_c = 1'b1;
        result_c  = '0;
        if (a_qnan) begin
            result_c = a;
        end else if (b_qnan) begin
            result_c = b;
        end else if (a_snan) begin
            result_c = a;
            result_c.mantissa[`FP_QNAN_BIT] = 1'b1;
        end else if (b_snan) begin
            result_c = b;
            result_c.mantissa[`FP_QNAN_BIT] = 1'b1;
        end else if (a_inf && b_inf) begin
            result_c = (a.sign == b.sign) ? a : fp_add_pkg::fp32_t'(`FP_DEFAULT_NAN);
        end else if (a_inf) begin
            result_c = a;
        end else if (b_inf) begin
            result_c = b;
        end else if ((a_zero || a_den) && (b_zero || b_den)) begin
            if (a.sign == b.sign) begin
                result_c = a;
            end else begin
                // opposite zeros give +0, except -0 when rounding down
                result_c.sign = (rm_q == fp_add_pkg::RDN);
            end
        end else if (a_zero || a_den) begin
            result_c = b;
        end else if (b_zero || b_den) begin
            result_c = a;
        end else begin
            special_c = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op1               <= '0;
            op2               <= '0;
            sb.valid          <= 1'b0;
            sb.round_mode     <= fp_add_pkg::RNE;
            sb.special_case   <= 1'b0;
            sb.special_result <= '0;
            sb.invalid        <= 1'b0;
            sb.flushed        <= 1'b0;
        end else begin
            op1               <= a;
            op2               <= b;
            sb.valid          <= valid_q;
            sb.round_mode     <= rm_q;
            sb.special_case   <= special_c;
            sb.special_result <= result_c;
            sb.invalid        <= a_snan || b_snan || (a_inf && b_inf && (a.sign != b.sign));
            sb.flushed        <= a_den || b_den;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp_mantissa_add.sv
// stage 3 of the adder: forms sum and difference of the extended mantissas and spots exact zero
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_mantissa_add (
    input  logic               clk,
    input  logic               rst,
    fp_sideband_if.dst         sb_in,
    input  fp_add_pkg::align_t aligned,
    fp_sideband_if.src         sb_out,
    output fp_add_pkg::sum_t   sum
);

    logic [`FP_EXT_W-1:0] big_man;

    // larger mantissa with hidden bit and empty grs positions
    assign big_man = {1'b1, aligned.larger.mantissa, 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum                   <= '0;
            sb_out.valid          <= 1'b0;
            sb_out.round_mode     <= fp_add_pkg::RNE;
            sb_out.special_case   <= 1'b0;
            sb_out.special_result <= '0;
            sb_out.invalid        <= 1'b0;
            sb_out.flushed        <= 1'b0;
        end else begin
            sum.add_res           <= {1'b0, big_man} + {1'b0, aligned.small_man};
            // never negative, the larger magnitude is always on the left
            sum.sub_res           <= big_man - aligned.small_man;
            sum.sign              <= aligned.larger.sign;
            sum.exponent          <= aligned.larger.exponent;
            sum.sticky            <= aligned.sticky;
            sum.sub               <= aligned.sub;
            sum.exact_zero        <= aligned.sub && (big_man == aligned.small_man);
            sb_out.valid          <= sb_in.valid;
            sb_out.round_mode     <= sb_in.round_mode;
            sb_out.special_case   <= sb_in.special_case;
            sb_out.special_result <= sb_in.special_result;
            sb_out.invalid        <= sb_in.invalid;
            sb_out.flushed        <= sb_in.flushed;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp_normalize_round.sv
// stage 4 of the adder: normalizes, rounds, picks the exception result and registers the outputs
`timescale 1ns/1ps
`default_nettype none

`include "fp_add_macros.svh"

module fp_normalize_round (
    input  logic             clk,
    input  logic             rst,
    fp_sideband_if.dst       sb,
    input  fp_add_pkg::sum_t sum,
    output logic [31:0]      out,
    output logic             overflow,
    output logic             underflow,
    output logic             inexact,
    output logic             invalid_operation,
    output logic             valid_data_out
);

    logic [4:0]           lzc;
    logic [`FP_EXT_W-1:0] sub_norm;
    logic [`FP_MAN_W-1:0] norm_man;
    logic [`FP_EXP_W:0]   norm_exp;
    logic                 guard, round, sticky, grs;
    logic                 round_up;
    logic [`FP_MAN_W:0]   man_inc;
    logic [`FP_MAN_W-1:0] rnd_man;
    logic [`FP_EXP_W:0]   rnd_exp;
    logic                 exp_ovf, exp_unf;
    logic                 rdn;
    logic [31:0]          max_finite, infinity;

    // leading zeros of the difference, highest set bit wins
    always_comb begin
        lzc = 5'd0;
        for (int i = 0; i < `FP_EXT_W; i++) begin
            if (sum.sub_res[i]) begin
                lzc = 5'(`FP_EXT_W - 1 - i);
            end
        end
    end

    assign sub_norm = sum.sub_res << lzc;

    always_comb begin
        if (sum.sub) begin
            norm_man = sub_norm[`FP_EXT_W-2:3];
            guard    = sub_norm[2];
            round    = sub_norm[1];
            sticky   = sub_norm[0] | sum.sticky;
            norm_exp = {1'b0, sum.exponent} - {4'b0000, lzc};
        end else if (sum.add_res[`FP_EXT_W]) begin
            // carry out, one position right
            norm_man = sum.add_res[`FP_EXT_W-1:4];
            guard    = sum.add_res[3];
            round    = sum.add_res[2];
            sticky   = sum.add_res[1] | sum.add_res[0] | sum.sticky;
            norm_exp = {1'b0, sum.exponent} + 9'd1;
        end else begin
            norm_man = sum.add_res[`FP_EXT_W-2:3];
            guard    = sum.add_res[2];
            round    = sum.add_res[1];
            sticky   = sum.add_res[0] | sum.sticky;
            norm_exp = {1'b0, sum.exponent};
        end
    end

    assign grs = guard | round | sticky;
    assign rdn = (sb.round_mode == fp_add_pkg::RDN);

    always_comb begin
        case (sb.round_mode)
            fp_add_pkg::RNE: round_up = guard & (round | sticky | norm_man[0]);
            fp_add_pkg::RDN: round_up = sum.sign & grs;
            fp_add_pkg::RUP: round_up = !sum.sign & grs;
            fp_add_pkg::RMM: round_up = guard;
            default:         round_up = 1'b0;
        endcase
    end

    assign man_inc = {1'b0, norm_man} + {{`FP_MAN_W{1'b0}}, round_up};
    // a rounding carry leaves the fraction bits all zero
    assign rnd_man = man_inc[`FP_MAN_W-1:0];
    assign rnd_exp = norm_exp + {{`FP_EXP_W{1'b0}}, man_inc[`FP_MAN_W]};

    // msb of the 9-bit exponent marks a borrow below zero
    assign exp_ovf = !sum.sub && (rnd_exp > 9'(`FP_EXP_MAX_FINITE));
    assign exp_unf = sum.sub && ((rnd_exp == '0) || rnd_exp[`FP_EXP_W]);

    assign max_finite = {sum.sign, 8'(`FP_EXP_MAX_FINITE), {`FP_MAN_W{1'b1}}};
    assign infinity   = {sum.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out               <= '0;
            overflow          <= 1'b0;
            underflow         <= 1'b0;
            inexact           <= 1'b0;
            invalid_operation <= 1'b0;
            valid_data_out    <= 1'b0;
        end else begin
            invalid_operation <= sb.invalid;
            valid_data_out    <= sb.valid;
            overflow          <= 1'b0;
            underflow         <= 1'b0;
            inexact           <= sb.flushed | grs;
            if (sb.special_case) begin
                out       <= sb.special_result;
                underflow <= sb.flushed;
                inexact   <= 1'b0;
            end else if (sum.exact_zero) begin
                out       <= {rdn, 31'd0};
                underflow <= sb.flushed;
                inexact   <= 1'b0;
            end else if (exp_ovf) begin
                overflow <= 1'b1;
                // saturate when rounding toward zero in the direction of the sign
                case (sb.round_mode)
                    fp_add_pkg::RTZ: out <= max_finite;
                    fp_add_pkg::RDN: out <= sum.sign ? infinity : max_finite;
                    fp_add_pkg::RUP: out <= sum.sign ? max_finite : infinity;
                    default:         out <= infinity;
                endcase
            end else if (exp_unf) begin
                out       <= {sum.sign | rdn, 31'd0};
                underflow <= grs;
            end else begin
                out <= {sum.sign, rnd_exp[`FP_EXP_W-1:0], rnd_man};
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp_sideband_if.sv
// per-operation side-band that travels alongside the datapath from one stage to the next
`timescale 1ns/1ps
`default_nettype none

interface fp_sideband_if;

    logic                    valid;
    fp_add_pkg::round_mode_e round_mode;
    logic                    special_case;
    fp_add_pkg::fp32_t       special_result;
    // sNaN input or inf - inf
    logic                    invalid;
    // at least one denormal input was flushed
    logic                    flushed;

    modport src (
        output valid, round_mode, special_case, special_result, invalid, flushed
    );

    modport dst (
        input valid, round_mode, special_case, special_result, invalid, flushed
    );

endinterface

`default_nettype wire
